/* precompute_pipe.f */
+incdir+design
design/precompute_pkg.sv
design/reg_file.sv
design/alu.sv
design/issue_stage.sv
design/operand_stage.sv
design/execute_stage.sv
design/precompute_pipe.sv
tests/tb_clock.sv
tests/precompute_pipe_tb.sv

/* tests/precompute_pipe_tb.sv */
//------------------------------------------------
// Pipeline testbench
// Directed tests against an in-order model,
// with value, order and latency checks
//------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

`include "precompute_consts.svh"

module precompute_pipe_tb import precompute_pkg::*; ();

  localparam int CLK_PERIOD     = 10;
  localparam int RESET_CYCLES   = 4;
  localparam int NUM_INSTS      = 8 + 18 + 12 + 7 + 200; // Reset, opcodes, distance, priority, stream
  localparam int SLOTS_PER_INST = 5;                      // Widest spacing plus drain
  localparam int WATCHDOG_NS    = (NUM_INSTS * SLOTS_PER_INST + 20) * CLK_PERIOD
                                  + RESET_CYCLES * CLK_PERIOD;

  logic    clk;
  logic    rst;
  logic    in_vld;
  reg_t    in_ra_0;
  reg_t    in_ra_1;
  reg_t    in_wa;
  opcode_t in_op;
  word_t   in_imm;
  logic    out_vld;
  reg_t    out_wa;
  word_t   out_wdata;

  word_t       model_regs [`PP_NUM_REGS]; // Architectural state at issue time
  reg_t        exp_wa_q [$];
  word_t       exp_data_q [$];
  int          exp_cyc_q [$];              // Sampling edge of each instruction
  int          cycle = 0;
  logic [31:0] lcg_state = 32'd35;

  tb_clock u_tb_clock (.clk(clk), .rst(rst));

  precompute_pipe u_dut (
    .clk       (clk),
    .rst       (rst),
    .in_vld    (in_vld),
    .in_ra_0   (in_ra_0),
    .in_ra_1   (in_ra_1),
    .in_wa     (in_wa),
    .in_op     (in_op),
    .in_imm    (in_imm),
    .out_vld   (out_vld),
    .out_wa    (out_wa),
    .out_wdata (out_wdata)
  );

  always @(posedge clk) cycle <= cycle + 1; // Edge count

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Built from the upper LCG halves whose bits cycle slowest
  function automatic word_t rand_word();
    logic [31:0] hi;
    logic [31:0] lo;
    hi = lcg_next();
    lo = lcg_next();
    return {hi[31:16], lo[31:16]};
  endfunction

  function automatic word_t model_exec(opcode_t op, word_t imm, word_t a, word_t b);
    logic [`PP_OP_W-1:0] code;
    code = op;
    case (code)
      `PP_OP_AND:  return a & b;
      `PP_OP_NOT:  return ~a;
      `PP_OP_OR:   return a | b;
      `PP_OP_XOR:  return a ^ b;
      `PP_OP_ADD:  return a + b;   // Mod 2**32
      `PP_OP_SUB:  return a - b;
      `PP_OP_MOV0: return a;
      `PP_OP_MOV1: return b;
      `PP_OP_MOVI: return imm;
      default:     return a;       // Undefined codes
    endcase
  endfunction

  task automatic check_reg(string name, reg_t got, reg_t exp);
    if (got !== exp) begin
      $display("Fail %s: got %h, expected %h", name, got, exp);
      $display("Testbench failed");
      $fatal(1);
    end
  endtask

  task automatic check_word(string name, word_t got, word_t exp);
    if (got !== exp) begin
      $display("Fail %s: got %h, expected %h", name, got, exp);
      $display("Testbench failed");
      $fatal(1);
    end
  endtask

  // Model runs here in issue order
  task automatic issue_inst(reg_t ra_0, reg_t ra_1, reg_t wa, opcode_t op, word_t imm);
    word_t res;
    res = model_exec(op, imm, model_regs[ra_0], model_regs[ra_1]);
    model_regs[wa] = res;
    exp_wa_q.push_back(wa);
    exp_data_q.push_back(res);
    exp_cyc_q.push_back(cycle + 1); // Sampled on the next edge
    in_vld  = 1'b1;
    in_ra_0 = ra_0;
    in_ra_1 = ra_1;
    in_wa   = wa;
    in_op   = op;
    in_imm  = imm;
    @(posedge clk);
    #1;
    in_vld = 1'b0;
  endtask

  task automatic idle_cycles(int n);
    in_vld = 1'b0;
    repeat (n) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic wait_drain();
    while (exp_wa_q.size() != 0) begin
      @(posedge clk);
      #1;
    end
  endtask

  // Pops one expected entry per result at the falling edge
  always @(negedge clk) begin
    reg_t  exp_wa;
    word_t exp_data;
    int    exp_cyc;
    if (out_vld === 1'b1) begin
      if (exp_wa_q.size() == 0) begin
        $display("out_vld went high at cycle %0d with nothing issued", cycle);
        $display("Testbench failed");
        $fatal(1);
      end else begin
        exp_wa   = exp_wa_q.pop_front();
        exp_data = exp_data_q.pop_front();
        exp_cyc  = exp_cyc_q.pop_front();
        check_reg("out_wa", out_wa, exp_wa);
        check_word("out_wdata", out_wdata, exp_data);
        if (cycle - exp_cyc != 3) begin
          $display("Result sampled at edge %0d came %0d cycles later, not 3",
                   exp_cyc, cycle - exp_cyc);
          $display("Testbench failed");
          $fatal(1);
        end
      end
    end
  end

  task automatic test_reset();
    repeat (3) begin
      if (out_vld !== 1'b0) begin
        $display("out_vld is not low after reset before any issue");
        $display("Testbench failed");
        $fatal(1);
      end
      idle_cycles(1);
    end
    for (int i = 0; i < `PP_NUM_REGS; i++)
      issue_inst(reg_t'(i), reg_t'(i), reg_t'(i), OP_MOV0, 32'hdead_beef); // Expect zero
    wait_drain();
  endtask

  task automatic test_opcodes();
    for (int i = 0; i < `PP_NUM_REGS; i++)
      issue_inst(reg_t'(0), reg_t'(0), reg_t'(i), OP_MOVI, rand_word());
    idle_cycles(3);
    // Nine defined codes and undefined code 9 on sources this loop never writes
    for (int i = 0; i < 10; i++) begin
      issue_inst(reg_t'(i % 4), reg_t'(4 + i % 3), reg_t'(7), opcode_t'(4'(i)), rand_word());
      idle_cycles(3);
    end
    wait_drain();
  endtask

  // gap 0 hits EXE, gap 1 hits WB, gap 2 reads the array
  task automatic run_chain(int gap, word_t seed_val);
    issue_inst(3'd0, 3'd0, 3'd1, OP_MOVI, seed_val);
    idle_cycles(gap);
    issue_inst(3'd1, 3'd1, 3'd2, OP_ADD, '0);
    idle_cycles(gap);
    issue_inst(3'd2, 3'd1, 3'd3, OP_SUB, '0);
    idle_cycles(gap);
    issue_inst(3'd3, 3'd2, 3'd4, OP_XOR, '0);
    wait_drain();
  endtask

  task automatic test_forward_distance();
    run_chain(0, 32'h0000_1234);
    run_chain(1, 32'h8000_0001);
    run_chain(2, 32'hffff_fff0);
  endtask

  task automatic test_priority();
    issue_inst(3'd0, 3'd0, 3'd3, OP_MOVI, 32'h1111_0000);
    issue_inst(3'd0, 3'd0, 3'd3, OP_MOVI, 32'h0000_2222); // Younger writer
    issue_inst(3'd3, 3'd3, 3'd4, OP_ADD, '0);             // Same producer twice
    issue_inst(3'd0, 3'd0, 3'd1, OP_MOVI, 32'ha5a5_0f0f);
    issue_inst(3'd0, 3'd0, 3'd2, OP_MOVI, 32'h0123_4567);
    issue_inst(3'd1, 3'd2, 3'd5, OP_SUB, '0);             // WB and EXE mixed
    issue_inst(3'd5, 3'd5, 3'd6, OP_ADD, '0);             // Both operands from EXE
    wait_drain();
  endtask

  task automatic test_random_stream();
    logic [31:0] r;
    for (int i = 0; i < 200; i++) begin
      r = lcg_next();
      idle_cycles(int'(r[17:16])); // 0 to 3 idle cycles
      r = lcg_next();
      issue_inst(r[18:16], r[21:19], r[24:22], opcode_t'(4'(int'(r[31:25]) % 10)),
                 rand_word());
    end
    wait_drain();
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns with results still missing", WATCHDOG_NS);
    $display("Testbench failed");
    $fatal(1);
  end

  initial begin
    in_vld  = 1'b0;
    in_ra_0 = '0;
    in_ra_1 = '0;
    in_wa   = '0;
    in_op   = OP_AND;
    in_imm  = '0;
    for (int i = 0; i < `PP_NUM_REGS; i++)
      model_regs[i] = '0;
    wait (rst === 1'b0);
    @(posedge clk);
    #1;
    test_reset();
    test_opcodes();
    test_forward_distance();
    test_priority();
    test_random_stream();
    $display("Testbench passed");
    $finish;
  end

endmodule

`default_nettype wire

/* tests/tb_clock.sv */
//------------------------------------------------
// Testbench clock and reset
// 10 ns clock, reset held for 4 cycles
//------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module tb_clock (
  output logic clk,
  output logic rst
);

  localparam int HALF_PERIOD  = 5;
  localparam int RESET_CYCLES = 4;

  initial begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

  // Released 1 ns after the edge, same as the other inputs
  initial begin
    rst = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    #1 rst = 1'b0;
  end

endmodule

`default_nettype wire

/* design/precompute_pipe.sv */
//------------------------------------------------
// Precompute pipeline top
// Four stages with issue-time bypass selects,
// results 3 cycles after sampling
//------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module precompute_pipe import precompute_pkg::*; (
  input  logic    clk,
  input  logic    rst,
  input  logic    in_vld,
  input  reg_t    in_ra_0,
  input  reg_t    in_ra_1,
  input  reg_t    in_wa,
  input  opcode_t in_op,
  input  word_t   in_imm,
  output logic    out_vld,
  output reg_t    out_wa,
  output word_t   out_wdata
);

  // S1 contents
  logic     s1_vld;
  inst_t    s1_inst;
  word_t    s1_imm;
  fwd_sel_t s1_sel_0;
  fwd_sel_t s1_sel_1;

  // S2 contents, operands resolved
  logic     s2_vld;
  reg_t     s2_wa;
  opcode_t  s2_op;
  word_t    s2_imm;
  word_t    s2_opnd_0;
  word_t    s2_opnd_1;

  word_t    exe_result; // S3 bypass

  issue_stage u_issue_stage (
    .clk      (clk),
    .rst      (rst),
    .in_vld   (in_vld),
    .in_ra_0  (in_ra_0),
    .in_ra_1  (in_ra_1),
    .in_wa    (in_wa),
    .in_op    (in_op),
    .in_imm   (in_imm),
    .s2_vld   (s2_vld),   // Looked back for the compare
    .s2_wa    (s2_wa),
    .s1_vld   (s1_vld),
    .s1_inst  (s1_inst),
    .s1_imm   (s1_imm),
    .s1_sel_0 (s1_sel_0),
    .s1_sel_1 (s1_sel_1)
  );

  // Writeback outputs double as the register file write port
  operand_stage u_operand_stage (
    .clk        (clk),
    .rst        (rst),
    .s1_vld     (s1_vld),
    .s1_inst    (s1_inst),
    .s1_imm     (s1_imm),
    .s1_sel_0   (s1_sel_0),
    .s1_sel_1   (s1_sel_1),
    .exe_result (exe_result),
    .wb_vld     (out_vld),
    .wb_wa      (out_wa),
    .wb_wdata   (out_wdata),
    .s2_vld     (s2_vld),
    .s2_wa      (s2_wa),
    .s2_op      (s2_op),
    .s2_imm     (s2_imm),
    .s2_opnd_0  (s2_opnd_0),
    .s2_opnd_1  (s2_opnd_1)
  );

  execute_stage u_execute_stage (
    .clk        (clk),
    .rst        (rst),
    .s2_vld     (s2_vld),
    .s2_wa      (s2_wa),
    .s2_op      (s2_op),
    .s2_imm     (s2_imm),
    .s2_opnd_0  (s2_opnd_0),
    .s2_opnd_1  (s2_opnd_1),
    .exe_result (exe_result),
    .wb_vld     (out_vld),
    .wb_wa      (out_wa),
    .wb_wdata   (out_wdata)
  );

endmodule

`default_nettype wire

/* design/execute_stage.sv */
//------------------------------------------------
// Execute stage (S3) and writeback register (S4)
// ALU output is also the S3 bypass source
//------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module execute_stage import precompute_pkg::*; (
  input  logic    clk,
  input  logic    rst,
  input  logic    s2_vld,
  input  reg_t    s2_wa,
  input  opcode_t s2_op,
  input  word_t   s2_imm,
  input  word_t   s2_opnd_0,
  input  word_t   s2_opnd_1,
  output word_t   exe_result,
  output logic    wb_vld,
  output reg_t    wb_wa,
  output word_t   wb_wdata
);

  logic    s3_vld;
  reg_t    s3_wa;
  opcode_t s3_op;
  word_t   s3_imm;
  word_t   s3_opnd_0;
  word_t   s3_opnd_1;

  // Valid flags for S3 and S4
  always_ff @(posedge clk) begin
    if (rst) begin
      s3_vld <= 1'b0;
      wb_vld <= 1'b0;
    end else begin
      s3_vld <= s2_vld;
      wb_vld <= s3_vld;
    end
  end

  // S3 payload, operands already resolved
  always_ff @(posedge clk) begin
    if (s2_vld) begin
      s3_wa     <= s2_wa;
      s3_op     <= s2_op;
      s3_imm    <= s2_imm;
      s3_opnd_0 <= s2_opnd_0;
      s3_opnd_1 <= s2_opnd_1;
    end
  end

  alu u_alu (
    .op     (s3_op),
    .imm    (s3_imm),
    .opnd_0 (s3_opnd_0),
    .opnd_1 (s3_opnd_1),
    .result (exe_result)
  );

  always_ff @(posedge clk) begin
    if (s3_vld) begin
      wb_wa    <= s3_wa;
      wb_wdata <= exe_result; // Held in S4 for one cycle, then written
    end
  end

endmodule

`default_nettype wire

/* design/operand_stage.sv */
//------------------------------------------------
// Operand stage (S2)
// Register file read and bypass mux steered by
// the selects stored at issue
//------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module operand_stage import precompute_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  logic     s1_vld,
  input  inst_t    s1_inst,
  input  word_t    s1_imm,
  input  fwd_sel_t s1_sel_0,
  input  fwd_sel_t s1_sel_1,
  input  word_t    exe_result,
  input  logic     wb_vld,
  input  reg_t     wb_wa,
  input  word_t    wb_wdata,
  output logic     s2_vld,
  output reg_t     s2_wa,
  output opcode_t  s2_op,
  output word_t    s2_imm,
  output word_t    s2_opnd_0,
  output word_t    s2_opnd_1
);

  inst_t    s2_inst;
  fwd_sel_t s2_sel_0;
  fwd_sel_t s2_sel_1;
  word_t    rf_rdata_0;
  word_t    rf_rdata_1;

  always_ff @(posedge clk) begin
    if (rst)
      s2_vld <= 1'b0;
    else
      s2_vld <= s1_vld;
  end

  always_ff @(posedge clk) begin
    if (s1_vld) begin
      s2_inst  <= s1_inst;
      s2_imm   <= s1_imm;
      s2_sel_0 <= s1_sel_0;
      s2_sel_1 <= s1_sel_1;
    end
  end

  reg_file u_reg_file (
    .clk     (clk),
    .rst     (rst),
    .ra_0    (s2_inst.ra_0),
    .ra_1    (s2_inst.ra_1),
    .rdata_0 (rf_rdata_0),
    .rdata_1 (rf_rdata_1),
    .wen     (wb_vld),   // S4 retires into the array
    .wa      (wb_wa),
    .wdata   (wb_wdata)
  );

  // Plain mux, no compares left at this point
  always_comb begin
    case (s2_sel_0)
      FWD_EXE: s2_opnd_0 = exe_result;
      FWD_WB:  s2_opnd_0 = wb_wdata;
      default: s2_opnd_0 = rf_rdata_0;
    endcase
    case (s2_sel_1)
      FWD_EXE: s2_opnd_1 = exe_result;
      FWD_WB:  s2_opnd_1 = wb_wdata;
      default: s2_opnd_1 = rf_rdata_1;
    endcase
  end

  assign s2_wa = s2_inst.wa;
  assign s2_op = s2_inst.op;

endmodule

`default_nettype wire

/* design/issue_stage.sv */
//------------------------------------------------
// Issue stage (S1)
// Samples the instruction and precomputes the
// bypass source of both operands
//------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module issue_stage import precompute_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  logic     in_vld,
  input  reg_t     in_ra_0,
  input  reg_t     in_ra_1,
  input  reg_t     in_wa,
  input  opcode_t  in_op,
  input  word_t    in_imm,
  input  logic     s2_vld,
  input  reg_t     s2_wa,
  output logic     s1_vld,
  output inst_t    s1_inst,
  output word_t    s1_imm,
  output fwd_sel_t s1_sel_0,
  output fwd_sel_t s1_sel_1
);

  fwd_sel_t sel_0_nxt;
  fwd_sel_t sel_1_nxt;

  // S1 producer will sit in S3 when this one reads in S2, so it wins
  // S2 producer will sit in S4 by then
  // Anything older has already been written to the register file
  always_comb begin
    if (s1_vld && (s1_inst.wa == in_ra_0))
      sel_0_nxt = FWD_EXE;
    else if (s2_vld && (s2_wa == in_ra_0))
      sel_0_nxt = FWD_WB;
    else
      sel_0_nxt = FWD_RF;

    if (s1_vld && (s1_inst.wa == in_ra_1))
      sel_1_nxt = FWD_EXE;
    else if (s2_vld && (s2_wa == in_ra_1))
      sel_1_nxt = FWD_WB;
    else
      sel_1_nxt = FWD_RF;
  end

  always_ff @(posedge clk) begin
    if (rst)
      s1_vld <= 1'b0;
    else
      s1_vld <= in_vld; // One strobe per instruction
  end

  // Payload and selects only move on a real issue
  always_ff @(posedge clk) begin
    if (in_vld) begin
      s1_inst.ra_0 <= in_ra_0;
      s1_inst.ra_1 <= in_ra_1;
      s1_inst.wa   <= in_wa;
      s1_inst.op   <= in_op;
      s1_imm       <= in_imm;
      s1_sel_0     <= sel_0_nxt;
      s1_sel_1     <= sel_1_nxt;
    end
  end

endmodule

`default_nettype wire

/* design/alu.sv */
//------------------------------------------------
// ALU
// Combinational execution of the opcode set
//------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module alu import precompute_pkg::*; (
  input  opcode_t op,
  input  word_t   imm,
  input  word_t   opnd_0,
  input  word_t   opnd_1,
  output word_t   result
);

  always_comb begin
    case (op)
      OP_AND:  result = opnd_0 & opnd_1;
      OP_NOT:  result = ~opnd_0;          // Operand 1 ignored
      OP_OR:   result = opnd_0 | opnd_1;
      OP_XOR:  result = opnd_0 ^ opnd_1;
      OP_ADD:  result = opnd_0 + opnd_1;  // Wraps at 32 bits
      OP_SUB:  result = opnd_0 - opnd_1;
      OP_MOV0: result = opnd_0;
      OP_MOV1: result = opnd_1;
      OP_MOVI: result = imm;
      default: result = opnd_0;           // Unknown codes pass operand 0
    endcase
  end

endmodule

`default_nettype wire

/* design/reg_file.sv */
//------------------------------------------------
// Register file
// Eight words, two async reads, one write port
//------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

`include "precompute_consts.svh"

module reg_file (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [`PP_REG_W-1:0]  ra_0,
  input  logic [`PP_REG_W-1:0]  ra_1,
  output logic [`PP_WORD_W-1:0] rdata_0,
  output logic [`PP_WORD_W-1:0] rdata_1,
  input  logic                  wen,
  input  logic [`PP_REG_W-1:0]  wa,
  input  logic [`PP_WORD_W-1:0] wdata
);

  logic [`PP_WORD_W-1:0] regs [`PP_NUM_REGS];

  // Whole array cleared so every register reads zero after reset
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `PP_NUM_REGS; i++)
        regs[i] <= '0;
    end else if (wen) begin
      regs[wa] <= wdata; // Write lands at the edge ending S4
    end
  end

  // No write-through, same-cycle producer comes in over FWD_WB
  assign rdata_0 = regs[ra_0];
  assign rdata_1 = regs[ra_1];

endmodule

`default_nettype wire

/* design/precompute_pkg.sv */
//------------------------------------------------
// Precompute pipeline types
// Data words, instructions and bypass selects
//------------------------------------------------
`default_nettype none

`include "precompute_consts.svh"

package precompute_pkg;

  typedef logic [`PP_WORD_W-1:0] word_t;
  typedef logic [`PP_REG_W-1:0]  reg_t;

  typedef enum logic [`PP_OP_W-1:0] {
    OP_AND  = `PP_OP_AND,
    OP_NOT  = `PP_OP_NOT,
    OP_OR   = `PP_OP_OR,
    OP_XOR  = `PP_OP_XOR,
    OP_ADD  = `PP_OP_ADD,
    OP_SUB  = `PP_OP_SUB,
    OP_MOV0 = `PP_OP_MOV0,
    OP_MOV1 = `PP_OP_MOV1,
    OP_MOVI = `PP_OP_MOVI
  } opcode_t;

  // 13 bits, immediate travels separately
  typedef struct packed {
    reg_t    ra_1;
    reg_t    ra_0;
    reg_t    wa;
    opcode_t op;
  } inst_t;

  // Where an operand is taken from in S2
  typedef enum logic [1:0] {
    FWD_RF  = 2'd0, // Register file
    FWD_EXE = 2'd1, // S3 ALU output
    FWD_WB  = 2'd2  // S4 writeback register
  } fwd_sel_t;

endpackage

`default_nettype wire

/* design/precompute_consts.svh */
//------------------------------------------------
// Precompute pipeline constants
// Widths, register count and opcode encodings
//------------------------------------------------
`ifndef PRECOMPUTE_CONSTS_SVH
`define PRECOMPUTE_CONSTS_SVH

`define PP_WORD_W    32 // Data word
`define PP_REG_W     3  // Register address
`define PP_NUM_REGS  8
`define PP_OP_W      4

// Opcode codes
`define PP_OP_AND    4'd0
`define PP_OP_NOT    4'd1
`define PP_OP_OR     4'd2
`define PP_OP_XOR    4'd3
`define PP_OP_ADD    4'd4
`define PP_OP_SUB    4'd5
`define PP_OP_MOV0   4'd6
`define PP_OP_MOV1   4'd7
`define PP_OP_MOVI   4'd8

`endif
